/* src/exec_pkg.sv */
package exec_pkg;

  localparam int XLEN = 32;

  // Cycles from the enable pulse to the ready pulse
  localparam int MUL_LATENCY = 17;
  localparam int DIV_LATENCY = 33;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [1:0] byte_off_t;

  // Holds either a mul_op_t or a div_op_t value
  typedef logic [1:0] unit_op_t;

  typedef enum logic [3:0] {
    KIND_ALU,
    KIND_LUI,
    KIND_AUIPC,
    KIND_JUMP,
    KIND_MUL,
    KIND_DIV,
    KIND_LOAD,
    KIND_STORE,
    KIND_NOP
  } exec_kind_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef enum logic [1:0] {MUL_LO, MUL_HSS, MUL_HSU, MUL_HUU} mul_op_t;

  typedef enum logic [1:0] {DIV_S, DIV_U, REM_S, REM_U} div_op_t;

  typedef enum logic [2:0] {LD_B, LD_H, LD_W, LD_BU, LD_HU} load_op_t;

endpackage

/* src/exec_unit_if.sv */
`timescale 1ns/1ps

interface exec_unit_if;

  // Driven by the stage
  logic enable;
  exec_pkg::unit_op_t op;
  exec_pkg::xlen_t rdata1;
  exec_pkg::xlen_t rdata2;

  // Driven by the unit, ready is a one-cycle pulse
  logic ready;
  exec_pkg::xlen_t result;

  modport stage (
    output enable, op, rdata1, rdata2,
    input ready, result
  );

  modport unit (
    input enable, op, rdata1, rdata2,
    output ready, result
  );

endinterface

/* src/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
  input exec_pkg::xlen_t a,
  input exec_pkg::xlen_t b,
  input exec_pkg::xlen_t imm,
  input logic use_imm,
  input exec_pkg::alu_op_t op,
  output exec_pkg::xlen_t result
);

  exec_pkg::xlen_t opb;
  logic [4:0] shamt;

  always_comb begin
    opb = use_imm ? imm : b;
    shamt = opb[4:0];
    case (op)
      exec_pkg::ALU_ADD: begin
        result = a + opb;
      end
      exec_pkg::ALU_SUB: begin
        result = a - opb;
      end
      exec_pkg::ALU_SLL: begin
        result = a << shamt;
      end
      exec_pkg::ALU_SLT: begin
        result = {31'b0, $signed(a) < $signed(opb)};
      end
      exec_pkg::ALU_SLTU: begin
        result = {31'b0, a < opb};
      end
      exec_pkg::ALU_XOR: begin
        result = a ^ opb;
      end
      exec_pkg::ALU_SRL: begin
        result = a >> shamt;
      end
      exec_pkg::ALU_SRA: begin
        // Arithmetic shift keeps the sign bit
        result = $signed(a) >>> shamt;
      end
      exec_pkg::ALU_OR: begin
        result = a | opb;
      end
      exec_pkg::ALU_AND: begin
        result = a & opb;
      end
      default: begin
        result = a + opb;
      end
    endcase
  end

endmodule

/* src/seq_multiplier.sv */
`timescale 1ns/1ps

module seq_multiplier (
  input logic clk,
  input logic rst,
  exec_unit_if.unit bus
);

  exec_pkg::mul_op_t op;
  logic a_neg;
  logic b_neg;
  exec_pkg::xlen_t a_mag;
  exec_pkg::xlen_t b_mag;
  logic busy;
  logic last;
  logic [$clog2(exec_pkg::MUL_LATENCY)-1:0] cnt;
  logic [63:0] mcand;
  logic [31:0] mplier;
  logic [63:0] acc;
  logic [63:0] acc_next;
  logic [63:0] prod;
  logic neg;
  logic high;

  always_comb begin
    op = exec_pkg::mul_op_t'(bus.op);
    a_neg = bus.rdata1[31] & (op == exec_pkg::MUL_HSS || op == exec_pkg::MUL_HSU);
    b_neg = bus.rdata2[31] & (op == exec_pkg::MUL_HSS);
    a_mag = a_neg ? -bus.rdata1 : bus.rdata1;
    b_mag = b_neg ? -bus.rdata2 : bus.rdata2;
    // Two multiplier bits per step
    acc_next = acc;
    if (mplier[0]) begin
      acc_next = acc_next + mcand;
    end
    if (mplier[1]) begin
      acc_next = acc_next + {mcand[62:0], 1'b0};
    end
    prod = neg ? -acc_next : acc_next;
  end

  assign last = busy && (cnt == ($bits(cnt))'(exec_pkg::MUL_LATENCY - 2));

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy <= 1'b0;
      cnt <= '0;
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= 1'b0;
      if (bus.enable) begin
        busy <= 1'b1;
        cnt <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (last) begin
          busy <= 1'b0;
          bus.ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.enable) begin
      mcand <= {32'b0, a_mag};
      mplier <= b_mag;
      acc <= '0;
      neg <= a_neg ^ b_neg;
      high <= op != exec_pkg::MUL_LO;
    end else if (busy) begin
      acc <= acc_next;
      mcand <= {mcand[61:0], 2'b00};
      mplier <= {2'b00, mplier[31:2]};
      if (last) begin
        bus.result <= high ? prod[63:32] : prod[31:0];
      end
    end
  end

endmodule

/* src/iter_divider.sv */
`timescale 1ns/1ps

module iter_divider (
  input logic clk,
  input logic rst,
  exec_unit_if.unit bus
);

  exec_pkg::div_op_t op;
  logic is_signed;
  logic a_neg;
  logic b_neg;
  exec_pkg::xlen_t a_mag;
  exec_pkg::xlen_t b_mag;
  logic busy;
  logic last;
  logic [$clog2(exec_pkg::DIV_LATENCY)-1:0] cnt;
  exec_pkg::xlen_t quo;
  exec_pkg::xlen_t rem;
  exec_pkg::xlen_t dvsr;
  exec_pkg::xlen_t dividend;
  logic q_neg;
  logic r_neg;
  logic is_rem;
  logic div_zero;
  logic [32:0] shifted;
  logic [32:0] diff;
  logic fits;
  exec_pkg::xlen_t quo_next;
  exec_pkg::xlen_t rem_next;
  exec_pkg::xlen_t q_res;
  exec_pkg::xlen_t r_res;

  always_comb begin
    op = exec_pkg::div_op_t'(bus.op);
    is_signed = (op == exec_pkg::DIV_S) || (op == exec_pkg::REM_S);
    a_neg = is_signed & bus.rdata1[31];
    b_neg = is_signed & bus.rdata2[31];
    a_mag = a_neg ? -bus.rdata1 : bus.rdata1;
    b_mag = b_neg ? -bus.rdata2 : bus.rdata2;

    // One restoring step, bring down the next dividend bit
    shifted = {rem, quo[31]};
    diff = shifted - {1'b0, dvsr};
    fits = !diff[32];
    rem_next = fits ? diff[31:0] : shifted[31:0];
    quo_next = {quo[30:0], fits};

    // Most negative over minus one already yields the dividend and zero
    q_res = q_neg ? -quo_next : quo_next;
    r_res = r_neg ? -rem_next : rem_next;
    if (div_zero) begin
      q_res = '1;
      r_res = dividend;
    end
  end

  assign last = busy && (cnt == ($bits(cnt))'(exec_pkg::DIV_LATENCY - 2));

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy <= 1'b0;
      cnt <= '0;
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= 1'b0;
      if (bus.enable) begin
        busy <= 1'b1;
        cnt <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (last) begin
          busy <= 1'b0;
          bus.ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.enable) begin
      quo <= a_mag;
      rem <= '0;
      dvsr <= b_mag;
      dividend <= bus.rdata1;
      q_neg <= a_neg ^ b_neg;
      r_neg <= a_neg;
      is_rem <= (op == exec_pkg::REM_S) || (op == exec_pkg::REM_U);
      div_zero <= bus.rdata2 == '0;
    end else if (busy) begin
      quo <= quo_next;
      rem <= rem_next;
      if (last) begin
        bus.result <= is_rem ? r_res : q_res;
      end
    end
  end

endmodule

/* src/load_align.sv */
`timescale 1ns/1ps

module load_align (
  input exec_pkg::xlen_t rdata,
  input exec_pkg::byte_off_t off,
  input exec_pkg::load_op_t op,
  output exec_pkg::xlen_t result
);

  exec_pkg::xlen_t shifted;

  always_comb begin
    // Addressed byte or halfword down to bit 0
    shifted = rdata >> {off, 3'b000};
    case (op)
      exec_pkg::LD_B: begin
        result = {{24{shifted[7]}}, shifted[7:0]};
      end
      exec_pkg::LD_BU: begin
        result = {24'b0, shifted[7:0]};
      end
      exec_pkg::LD_H: begin
        result = {{16{shifted[15]}}, shifted[15:0]};
      end
      exec_pkg::LD_HU: begin
        result = {16'b0, shifted[15:0]};
      end
      exec_pkg::LD_W: begin
        result = rdata;
      end
      default: begin
        result = rdata;
      end
    endcase
  end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input logic clk,
  input logic rst,
  input logic issue,
  input exec_pkg::exec_kind_t kind,
  input exec_pkg::alu_op_t alu_op,
  input exec_pkg::mul_op_t mul_op,
  input exec_pkg::div_op_t div_op,
  input exec_pkg::load_op_t load_op,
  input logic use_imm,
  input exec_pkg::xlen_t pc,
  input exec_pkg::xlen_t imm,
  input exec_pkg::xlen_t rdata1,
  input exec_pkg::xlen_t rdata2,
  input logic wren,
  input exec_pkg::reg_addr_t waddr,
  input exec_pkg::byte_off_t load_off,
  input exec_pkg::xlen_t dmem_rdata,
  input logic dmem_ready,
  input logic clear,
  input logic flush,
  input exec_pkg::xlen_t alu_result,
  input exec_pkg::xlen_t ldata,
  output exec_pkg::xlen_t alu_a,
  output exec_pkg::xlen_t alu_b,
  output exec_pkg::xlen_t alu_imm,
  output logic alu_use_imm,
  output exec_pkg::alu_op_t alu_fn,
  output exec_pkg::xlen_t mem_data,
  output exec_pkg::byte_off_t ld_off,
  output exec_pkg::load_op_t ld_op,
  exec_unit_if.stage mul_bus,
  exec_unit_if.stage div_bus,
  output logic reg_wren,
  output exec_pkg::reg_addr_t reg_waddr,
  output exec_pkg::xlen_t reg_wdata,
  output logic stall
);

  logic r_stall;
  logic h_valid, h_use_imm, h_wren;
  exec_pkg::exec_kind_t h_kind;
  exec_pkg::alu_op_t h_alu_op;
  exec_pkg::mul_op_t h_mul_op;
  exec_pkg::div_op_t h_div_op;
  exec_pkg::load_op_t h_load_op;
  exec_pkg::xlen_t h_pc, h_imm, h_rdata1, h_rdata2;
  exec_pkg::reg_addr_t h_waddr;
  exec_pkg::byte_off_t h_off;

  logic c_valid, c_use_imm, c_wren;
  exec_pkg::exec_kind_t c_kind;
  exec_pkg::mul_op_t c_mul_op;
  exec_pkg::div_op_t c_div_op;
  exec_pkg::xlen_t c_pc, c_imm, c_rdata1, c_rdata2;
  exec_pkg::reg_addr_t c_waddr;
  logic kill;
  logic busy;
  logic no_write;

  // Held copy while stalled, otherwise the incoming instruction
  assign c_valid = r_stall ? h_valid : issue;
  assign c_kind = r_stall ? h_kind : kind;
  assign c_mul_op = r_stall ? h_mul_op : mul_op;
  assign c_div_op = r_stall ? h_div_op : div_op;
  assign c_use_imm = r_stall ? h_use_imm : use_imm;
  assign c_pc = r_stall ? h_pc : pc;
  assign c_imm = r_stall ? h_imm : imm;
  assign c_rdata1 = r_stall ? h_rdata1 : rdata1;
  assign c_rdata2 = r_stall ? h_rdata2 : rdata2;
  assign c_wren = r_stall ? h_wren : wren;
  assign c_waddr = r_stall ? h_waddr : waddr;
  assign kill = clear | flush;

  assign alu_a = c_rdata1;
  assign alu_b = c_rdata2;
  assign alu_imm = c_imm;
  assign alu_use_imm = c_use_imm;
  assign alu_fn = r_stall ? h_alu_op : alu_op;
  assign mem_data = dmem_rdata;
  assign ld_off = r_stall ? h_off : load_off;
  assign ld_op = r_stall ? h_load_op : load_op;

  // Enables fire only in the first cycle of the instruction
  assign mul_bus.enable = c_valid && c_kind == exec_pkg::KIND_MUL && !r_stall && !kill;
  assign mul_bus.op = exec_pkg::unit_op_t'(c_mul_op);
  assign mul_bus.rdata1 = c_rdata1;
  assign mul_bus.rdata2 = c_rdata2;
  assign div_bus.enable = c_valid && c_kind == exec_pkg::KIND_DIV && !r_stall && !kill;
  assign div_bus.op = exec_pkg::unit_op_t'(c_div_op);
  assign div_bus.rdata1 = c_rdata1;
  assign div_bus.rdata2 = c_rdata2;

  always_comb begin
    busy = 1'b0;
    reg_wdata = alu_result;
    case (c_kind)
      exec_pkg::KIND_LUI: reg_wdata = c_imm;
      exec_pkg::KIND_AUIPC: reg_wdata = c_pc + c_imm;
      exec_pkg::KIND_JUMP: reg_wdata = c_pc + 32'd4;
      exec_pkg::KIND_MUL: begin
        // A ready seen in the first cycle is a leftover pulse
        busy = !(r_stall && mul_bus.ready);
        reg_wdata = mul_bus.result;
      end
      exec_pkg::KIND_DIV: begin
        busy = !(r_stall && div_bus.ready);
        reg_wdata = div_bus.result;
      end
      exec_pkg::KIND_LOAD: begin
        busy = !dmem_ready;
        reg_wdata = ldata;
      end
      exec_pkg::KIND_STORE: busy = !dmem_ready;
      default: busy = 1'b0;
    endcase
    no_write = c_kind == exec_pkg::KIND_STORE || c_kind == exec_pkg::KIND_NOP;
    stall = c_valid && busy && !kill;
    reg_wren = c_valid && c_wren && (|c_waddr) && !busy && !kill && !no_write;
  end

  assign reg_waddr = c_waddr;

  always_ff @(posedge clk) begin
    if (!rst) begin
      r_stall <= 1'b0;
      h_valid <= 1'b0;
    end else begin
      r_stall <= stall;
      if (kill) begin
        h_valid <= 1'b0;
      end else if (!r_stall) begin
        h_valid <= issue;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!r_stall) begin
      h_kind <= kind;
      h_alu_op <= alu_op;
      h_mul_op <= mul_op;
      h_div_op <= div_op;
      h_load_op <= load_op;
      h_use_imm <= use_imm;
      h_pc <= pc;
      h_imm <= imm;
      h_rdata1 <= rdata1;
      h_rdata2 <= rdata2;
      h_wren <= wren;
      h_waddr <= waddr;
      h_off <= load_off;
    end
  end

endmodule

/* src/execute_top.sv */
`timescale 1ns/1ps

module execute_top (
  input logic clk,
  input logic rst,
  input logic issue,
  input exec_pkg::exec_kind_t kind,
  input exec_pkg::alu_op_t alu_op,
  input exec_pkg::mul_op_t mul_op,
  input exec_pkg::div_op_t div_op,
  input exec_pkg::load_op_t load_op,
  input logic use_imm,
  input exec_pkg::xlen_t pc,
  input exec_pkg::xlen_t imm,
  input exec_pkg::xlen_t rdata1,
  input exec_pkg::xlen_t rdata2,
  input logic wren,
  input exec_pkg::reg_addr_t waddr,
  input exec_pkg::byte_off_t load_off,
  input exec_pkg::xlen_t dmem_rdata,
  input logic dmem_ready,
  input logic clear,
  input logic flush,
  output logic reg_wren,
  output exec_pkg::reg_addr_t reg_waddr,
  output exec_pkg::xlen_t reg_wdata,
  output logic stall
);

  exec_pkg::xlen_t alu_a, alu_b, alu_imm, alu_result;
  logic alu_use_imm;
  exec_pkg::alu_op_t alu_fn;
  exec_pkg::xlen_t mem_data, ldata;
  exec_pkg::byte_off_t ld_off;
  exec_pkg::load_op_t ld_op;

  exec_unit_if mul_bus ();
  exec_unit_if div_bus ();

  execute_stage u_stage (
    .clk(clk), .rst(rst), .issue(issue), .kind(kind),
    .alu_op(alu_op), .mul_op(mul_op), .div_op(div_op), .load_op(load_op),
    .use_imm(use_imm), .pc(pc), .imm(imm), .rdata1(rdata1), .rdata2(rdata2),
    .wren(wren), .waddr(waddr), .load_off(load_off),
    .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready), .clear(clear), .flush(flush),
    .alu_result(alu_result), .ldata(ldata),
    .alu_a(alu_a), .alu_b(alu_b), .alu_imm(alu_imm), .alu_use_imm(alu_use_imm),
    .alu_fn(alu_fn), .mem_data(mem_data), .ld_off(ld_off), .ld_op(ld_op),
    .mul_bus(mul_bus.stage), .div_bus(div_bus.stage),
    .reg_wren(reg_wren), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .stall(stall)
  );

  int_alu u_alu (
    .a(alu_a), .b(alu_b), .imm(alu_imm), .use_imm(alu_use_imm),
    .op(alu_fn), .result(alu_result)
  );

  seq_multiplier u_mul (.clk(clk), .rst(rst), .bus(mul_bus.unit));

  iter_divider u_div (.clk(clk), .rst(rst), .bus(div_bus.unit));

  load_align u_load (.rdata(mem_data), .off(ld_off), .op(ld_op), .result(ldata));

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Active low reset held for 4 cycles
  initial begin
    rst = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b1;
  end

endmodule

/* sim/execute_sva.sv */
`timescale 1ns/1ps

module execute_sva (
  input logic clk,
  input logic rst,
  input logic stall,
  input logic reg_wren,
  input exec_pkg::reg_addr_t reg_waddr,
  input logic clear,
  input logic flush
);

  int unsigned stall_run;

  // Length of the current run of stalled cycles
  always @(posedge clk) begin
    if (!rst) begin
      stall_run <= 0;
    end else if (stall) begin
      stall_run <= stall_run + 1;
    end else begin
      stall_run <= 0;
    end
  end

  no_write_to_x0: assert property (@(posedge clk) disable iff (!rst)
    reg_wren |-> reg_waddr != '0)
    else $error("register write to x0");

  quiet_after_reset: assert property (@(posedge clk)
    $rose(rst) |-> !stall && !reg_wren)
    else $error("stall or write in the first cycle after reset");

  stall_bounded: assert property (@(posedge clk) disable iff (!rst)
    stall_run <= exec_pkg::DIV_LATENCY + 4)
    else $error("stall held longer than the slowest unit");

  no_write_on_kill: assert property (@(posedge clk) disable iff (!rst)
    (clear || flush) |-> !reg_wren)
    else $error("register write during clear or flush");

endmodule

bind execute_top execute_sva u_sva (
  .clk(clk), .rst(rst), .stall(stall), .reg_wren(reg_wren),
  .reg_waddr(reg_waddr), .clear(clear), .flush(flush)
);

/* sim/execute_tb.sv */
`timescale 1ns/1ps

module execute_tb;

  // 23 single-cycle, 20 mul, 24 div, 24 memory, 2 killed, 4 to x0
  localparam int num_instr = 97;
  localparam int max_cycles = 60 * num_instr + 100;

  logic clk;
  logic rst;
  logic issue;
  exec_pkg::exec_kind_t kind;
  exec_pkg::alu_op_t alu_op;
  exec_pkg::mul_op_t mul_op;
  exec_pkg::div_op_t div_op;
  exec_pkg::load_op_t load_op;
  logic use_imm;
  exec_pkg::xlen_t pc;
  exec_pkg::xlen_t imm;
  exec_pkg::xlen_t rdata1;
  exec_pkg::xlen_t rdata2;
  logic wren;
  exec_pkg::reg_addr_t waddr;
  exec_pkg::byte_off_t load_off;
  exec_pkg::xlen_t dmem_rdata;
  logic dmem_ready;
  logic clear;
  logic flush;
  logic reg_wren;
  exec_pkg::reg_addr_t reg_waddr;
  exec_pkg::xlen_t reg_wdata;
  logic stall;

  integer seed = 32'h6379;
  int cycle_count = 0;
  int write_count = 0;
  logic exp_write = 1'b0;
  exec_pkg::reg_addr_t exp_waddr = '0;
  exec_pkg::xlen_t exp_wdata = '0;

  tb_clock u_clock (.clk(clk), .rst(rst));

  execute_top dut (.*);

  task automatic abort_run;
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("FAIL %s expected %h actual %h", name, expected, actual);
    abort_run();
  endtask

  task automatic plain_error(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  function automatic logic [31:0] alu_model(input exec_pkg::alu_op_t op,
                                            input logic [31:0] a, input logic [31:0] b);
    case (op)
      exec_pkg::ALU_ADD: return a + b;
      exec_pkg::ALU_SUB: return a - b;
      exec_pkg::ALU_SLL: return a << b[4:0];
      exec_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exec_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      exec_pkg::ALU_XOR: return a ^ b;
      exec_pkg::ALU_SRL: return a >> b[4:0];
      exec_pkg::ALU_SRA: return 32'($signed(a) >>> b[4:0]);
      exec_pkg::ALU_OR: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Full 64-bit product of the sign- or zero-extended operands
  function automatic logic [31:0] mul_model(input exec_pkg::mul_op_t op,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] p;
    ext_a = {{32{a[31] && op != exec_pkg::MUL_HUU}}, a};
    ext_b = {{32{b[31] && (op == exec_pkg::MUL_HSS || op == exec_pkg::MUL_LO)}}, b};
    p = ext_a * ext_b;
    return (op == exec_pkg::MUL_LO) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic [31:0] div_model(input exec_pkg::div_op_t op,
                                            input logic [31:0] a, input logic [31:0] b);
    logic sgn;
    logic [31:0] q;
    logic [31:0] r;
    sgn = (op == exec_pkg::DIV_S) || (op == exec_pkg::REM_S);
    if (b == 32'd0) begin
      q = 32'hffff_ffff;
      r = a;
    end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = a;
      r = 32'd0;
    end else if (sgn) begin
      q = 32'($signed(a) / $signed(b));
      r = 32'($signed(a) % $signed(b));
    end else begin
      q = a / b;
      r = a % b;
    end
    return (op == exec_pkg::DIV_S || op == exec_pkg::DIV_U) ? q : r;
  endfunction

  function automatic logic [31:0] load_model(input exec_pkg::load_op_t op,
                                             input logic [31:0] data, input logic [1:0] off);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = data[8*off +: 8];
    hi = (off == 2'd3) ? 8'h00 : data[8*off + 8 +: 8];
    case (op)
      exec_pkg::LD_B: return {{24{lo[7]}}, lo};
      exec_pkg::LD_BU: return {24'h0, lo};
      exec_pkg::LD_H: return {{16{hi[7]}}, hi, lo};
      exec_pkg::LD_HU: return {16'h0, hi, lo};
      default: return data;
    endcase
  endfunction

  // Every register write must match the pending instruction
  always @(negedge clk) begin
    if (rst && reg_wren) begin
      write_count = write_count + 1;
      assert (exp_write) else plain_error("Register write where none was expected");
      assert (reg_waddr == exp_waddr) else value_error("reg_waddr", exp_waddr, reg_waddr);
      assert (reg_wdata == exp_wdata) else value_error("reg_wdata", exp_wdata, reg_wdata);
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      plain_error("Run did not finish within the cycle limit");
    end
  end

  // Called and returns 1 ns after a rising edge
  task automatic run_instr(input exec_pkg::exec_kind_t k, input logic [31:0] a,
                           input logic [31:0] b, input exec_pkg::reg_addr_t wa,
                           input logic [31:0] value, input int lat, input int mem_delay);
    int stall_cycles;
    logic want;
    logic is_mem;
    stall_cycles = 0;
    is_mem = (k == exec_pkg::KIND_LOAD) || (k == exec_pkg::KIND_STORE);
    want = (wa != 5'd0) && (k != exec_pkg::KIND_STORE) && (k != exec_pkg::KIND_NOP);
    kind = k;
    rdata1 = a;
    rdata2 = b;
    waddr = wa;
    wren = 1'b1;
    issue = 1'b1;
    dmem_ready = is_mem && (mem_delay == 0);
    exp_write = want;
    exp_waddr = wa;
    exp_wdata = value;
    write_count = 0;
    @(negedge clk);
    while (stall) begin
      stall_cycles = stall_cycles + 1;
      @(posedge clk);
      #1;
      issue = 1'b0;
      if (is_mem && stall_cycles >= mem_delay) begin
        dmem_ready = 1'b1;
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    issue = 1'b0;
    dmem_ready = 1'b0;
    exp_write = 1'b0;
    assert (stall_cycles == lat) else value_error("stall cycles", lat, stall_cycles);
    assert (write_count == (want ? 1 : 0)) else value_error("reg_wren count",
                                                            want ? 1 : 0, write_count);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    int delay;
    issue = 1'b0;
    kind = exec_pkg::KIND_NOP;
    alu_op = exec_pkg::ALU_ADD;
    mul_op = exec_pkg::MUL_LO;
    div_op = exec_pkg::DIV_S;
    load_op = exec_pkg::LD_W;
    use_imm = 1'b0;
    pc = '0;
    imm = '0;
    rdata1 = '0;
    rdata2 = '0;
    wren = 1'b0;
    waddr = '0;
    load_off = '0;
    dmem_rdata = '0;
    dmem_ready = 1'b0;
    clear = 1'b0;
    flush = 1'b0;
    while (!rst) @(posedge clk);
    @(posedge clk);
    #1;

    for (int i = 0; i < 10; i++) begin
      for (int j = 0; j < 2; j++) begin
        a = $random(seed);
        b = $random(seed);
        imm = $random(seed);
        alu_op = exec_pkg::alu_op_t'(i);
        use_imm = (j == 1);
        run_instr(exec_pkg::KIND_ALU, a, b, 5'(i + 1), alu_model(alu_op, a, use_imm ? imm : b),
                  0, 0);
      end
    end
    pc = $random(seed);
    imm = $random(seed);
    run_instr(exec_pkg::KIND_LUI, 32'd0, 32'd0, 5'd11, imm, 0, 0);
    run_instr(exec_pkg::KIND_AUIPC, 32'd0, 32'd0, 5'd12, pc + imm, 0, 0);
    run_instr(exec_pkg::KIND_JUMP, 32'd0, 32'd0, 5'd1, pc + 32'd4, 0, 0);

    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 5; j++) begin
        a = (j == 3) ? 32'h8000_0000 : (j == 4) ? 32'hffff_ffff : $random(seed);
        b = (j == 3) ? 32'h8000_0000 : (j == 4) ? 32'h7fff_ffff : $random(seed);
        mul_op = exec_pkg::mul_op_t'(i);
        run_instr(exec_pkg::KIND_MUL, a, b, 5'd13, mul_model(mul_op, a, b),
                  exec_pkg::MUL_LATENCY, 0);
      end
    end

    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 6; j++) begin
        a = $random(seed);
        b = $random(seed);
        if (j == 3) begin
          b = 32'd0;
        end else if (j == 4) begin
          a = 32'h8000_0000;
          b = 32'hffff_ffff;
        end else if (j == 5) begin
          a = 32'hffff_fff9;
          b = 32'd2;
        end
        div_op = exec_pkg::div_op_t'(i);
        run_instr(exec_pkg::KIND_DIV, a, b, 5'd14, div_model(div_op, a, b),
                  exec_pkg::DIV_LATENCY, 0);
      end
    end

    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 4; j++) begin
        delay = $unsigned($random(seed)) % 4;
        dmem_rdata = $random(seed);
        load_op = exec_pkg::load_op_t'(i);
        load_off = 2'(j);
        run_instr(exec_pkg::KIND_LOAD, 32'd0, 32'd0, 5'd15,
                  load_model(load_op, dmem_rdata, load_off), delay, delay);
      end
    end
    for (int j = 0; j < 4; j++) begin
      delay = $unsigned($random(seed)) % 4;
      run_instr(exec_pkg::KIND_STORE, $random(seed), $random(seed), 5'd16, 32'd0, delay, delay);
    end

    // Drop a division while it holds the stage
    for (int i = 0; i < 2; i++) begin
      if (i == 0) begin
        delay = 2 + $unsigned($random(seed)) % 8;
      end else begin
        // Flush lands on the cycle the divider answers
        delay = exec_pkg::DIV_LATENCY - 1;
      end
      div_op = exec_pkg::DIV_U;
      kind = exec_pkg::KIND_DIV;
      rdata1 = $random(seed);
      rdata2 = $random(seed);
      waddr = 5'd20;
      wren = 1'b1;
      issue = 1'b1;
      exp_write = 1'b0;
      repeat (delay) begin
        @(posedge clk);
        #1;
        issue = 1'b0;
      end
      @(negedge clk);
      assert (stall) else plain_error("Division did not hold the stage");
      @(posedge clk);
      #1;
      clear = (i == 0);
      flush = (i == 1);
      @(negedge clk);
      assert (!stall) else plain_error("Stall stayed high during clear or flush");
      @(posedge clk);
      #1;
      clear = 1'b0;
      flush = 1'b0;
      repeat (exec_pkg::DIV_LATENCY + 2) begin
        @(negedge clk);
        assert (!stall) else plain_error("Stall came back after the division was dropped");
      end
      @(posedge clk);
      #1;
    end

    // Writes to x0 must stay silent
    run_instr(exec_pkg::KIND_ALU, 32'd5, 32'd7, 5'd0, 32'd0, 0, 0);
    run_instr(exec_pkg::KIND_LUI, 32'd0, 32'd0, 5'd0, 32'd0, 0, 0);
    run_instr(exec_pkg::KIND_MUL, 32'd3, 32'd9, 5'd0, 32'd0, exec_pkg::MUL_LATENCY, 0);
    dmem_rdata = $random(seed);
    run_instr(exec_pkg::KIND_LOAD, 32'd0, 32'd0, 5'd0, 32'd0, 2, 2);

    @(posedge clk);
    #1;
    $display("Test OK");
    $finish;
  end

endmodule

/* verilog.f */
src/exec_pkg.sv
src/exec_unit_if.sv
src/int_alu.sv
src/seq_multiplier.sv
src/iter_divider.sv
src/load_align.sv
src/execute_stage.sv
src/execute_top.sv
sim/tb_clock.sv
sim/execute_sva.sv
sim/execute_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module execute_tb -o execute_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/execute_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi

exit 0
